/* Makefile */
# Verilator flow for the dual-issue core and its testbench
TOP := tb_dual_issue

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# the run passes only if the testbench printed the pass line
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* hw/alu_lane.sv */
`include "core_params.svh"

module alu_lane (
	input  core_pkg::alu_op_e op,
	input  logic [`XLEN-1:0]  a,
	input  logic [`XLEN-1:0]  b,
	input  logic [`IMM_W-1:0] imm,
	output logic [`XLEN-1:0]  y
);

	// immediate widened two ways for the two immediate forms
	logic [`XLEN-1:0] imm_sext;
	logic [`XLEN-1:0] imm_upper;

	// ADDI takes the immediate sign extended to full width
	assign imm_sext = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};

	// LUI puts the immediate in the top half with the low half cleared
	assign imm_upper = {imm, {(`XLEN-`IMM_W){1'b0}}};

	// purely combinational, the result settles in the issue cycle
	always_comb begin
		case (op)
			core_pkg::OP_ADD:  y = a + b;
			core_pkg::OP_SUB:  y = a - b;
			core_pkg::OP_AND:  y = a & b;
			core_pkg::OP_OR:   y = a | b;
			core_pkg::OP_XOR:  y = a ^ b;
			// compare as two's complement, result is 1 or 0
			core_pkg::OP_SLT:  y = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			core_pkg::OP_ADDI: y = a + imm_sext;
			core_pkg::OP_LUI:  y = imm_upper;
			default:           y = '0;
		endcase
	end

endmodule

/* hw/clear_counter.sv */
`include "core_params.svh"

module clear_counter (
	input  logic                clk,
	input  logic                aresetn,
	input  logic                en,
	output logic [`RADDR_W-1:0] idx,
	output logic                last
);

	// x0 needs no clearing, so counting starts at 1
	// the count wraps to x0 on the last edge, when the sequencer drops the enable
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			idx <= `RADDR_W'(1);
		end else if (en) begin
			idx <= idx + `RADDR_W'(1);
		end
	end

	// the highest register index ends the sweep
	assign last = (idx == `RADDR_W'(`NREGS-1));

	// while the sequencer enables clearing, the index stays off x0
	assert property (@(posedge clk) disable iff (!aresetn)
		en |-> (idx != '0))
		else $error("clear_counter: index at x0 while clearing");

endmodule

/* hw/clear_fsm.sv */
module clear_fsm (
	input  logic clk,
	input  logic aresetn,
	input  logic last,
	output logic busy,
	output logic clr_en
);

	core_pkg::clear_state_e state;
	core_pkg::clear_state_e state_nxt;

	// clearing ends once the counter shows the last index
	// the last register is written on that same edge
	always_comb begin
		state_nxt = state;
		case (state)
			core_pkg::ST_CLEAR: begin
				if (last) begin
					state_nxt = core_pkg::ST_RUN;
				end
			end
			core_pkg::ST_RUN: begin
				state_nxt = core_pkg::ST_RUN;
			end
			default: begin
				state_nxt = core_pkg::ST_CLEAR;
			end
		endcase
	end

	// every reset, also one in the middle of a run, starts a fresh sweep
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= core_pkg::ST_CLEAR;
		end else begin
			state <= state_nxt;
		end
	end

	// busy and the clear enable cover the same window
	assign busy   = (state == core_pkg::ST_CLEAR);
	assign clr_en = (state == core_pkg::ST_CLEAR);

	// the run phase is only left through reset
	assert property (@(posedge clk) disable iff (!aresetn)
		(state == core_pkg::ST_RUN) |=> (state == core_pkg::ST_RUN))
		else $error("clear_fsm: left the run state without reset");

endmodule

/* hw/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

	// ALU operations understood by each lane
	// the three bits cover exactly eight operations, so no code is left unused
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_ADDI = 3'd6,
		OP_LUI  = 3'd7
	} alu_op_e;

	// phases of the core after reset
	// clearing zeroes the register file, running accepts instructions
	typedef enum logic {
		ST_CLEAR = 1'b0,
		ST_RUN   = 1'b1
	} clear_state_e;

	// one lane's instruction as it arrives at the core
	// rs2 is ignored by the immediate forms but is still read from the file
	typedef struct packed {
		logic                valid;
		alu_op_e             op;
		logic [`RADDR_W-1:0] rd;
		logic [`RADDR_W-1:0] rs1;
		logic [`RADDR_W-1:0] rs2;
		logic [`IMM_W-1:0]   imm;
	} issue_t;

	// one lane's registered result
	// it drives a register file write port and a result port at the same time
	typedef struct packed {
		logic                valid;
		logic [`RADDR_W-1:0] rd;
		logic [`XLEN-1:0]    data;
	} wb_t;

endpackage

/* hw/dual_issue_core.sv */
`include "core_params.svh"

module dual_issue_core (
	input  logic             clk,
	input  logic             aresetn,
	input  core_pkg::issue_t issue0,
	input  core_pkg::issue_t issue1,
	output logic             busy,
	output core_pkg::wb_t    result0,
	output core_pkg::wb_t    result1
);

	// sequencer to counter and register file
	logic                clr_en;
	logic                clr_last;
	logic [`RADDR_W-1:0] clr_idx;

	// execution stage read ports
	logic [`RADDR_W-1:0] raddr1;
	logic [`RADDR_W-1:0] raddr2;
	logic [`RADDR_W-1:0] raddr3;
	logic [`RADDR_W-1:0] raddr4;
	logic [`XLEN-1:0]    rdata1;
	logic [`XLEN-1:0]    rdata2;
	logic [`XLEN-1:0]    rdata3;
	logic [`XLEN-1:0]    rdata4;

	clear_fsm u_clear_fsm (
		.clk     (clk),
		.aresetn (aresetn),
		.last    (clr_last),
		.busy    (busy),
		.clr_en  (clr_en)
	);

	clear_counter u_clear_counter (
		.clk     (clk),
		.aresetn (aresetn),
		.en      (clr_en),
		.idx     (clr_idx),
		.last    (clr_last)
	);

	// the writeback registers double as the result ports
	reg_file u_reg_file (
		.clk      (clk),
		.aresetn  (aresetn),
		.we1      (result0.valid),
		.waddr1   (result0.rd),
		.wdata1   (result0.data),
		.we2      (result1.valid),
		.waddr2   (result1.rd),
		.wdata2   (result1.data),
		.clr_en   (clr_en),
		.clr_addr (clr_idx),
		.raddr1   (raddr1),
		.raddr2   (raddr2),
		.raddr3   (raddr3),
		.raddr4   (raddr4),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.rdata3   (rdata3),
		.rdata4   (rdata4)
	);

	exec_stage u_exec_stage (
		.clk     (clk),
		.aresetn (aresetn),
		.busy    (busy),
		.issue0  (issue0),
		.issue1  (issue1),
		.raddr1  (raddr1),
		.raddr2  (raddr2),
		.raddr3  (raddr3),
		.raddr4  (raddr4),
		.rdata1  (rdata1),
		.rdata2  (rdata2),
		.rdata3  (rdata3),
		.rdata4  (rdata4),
		.wb0     (result0),
		.wb1     (result1)
	);

endmodule

/* hw/exec_stage.sv */
`include "core_params.svh"

module exec_stage (
	input  logic                clk,
	input  logic                aresetn,
	input  logic                busy,
	input  core_pkg::issue_t    issue0,
	input  core_pkg::issue_t    issue1,
	output logic [`RADDR_W-1:0] raddr1,
	output logic [`RADDR_W-1:0] raddr2,
	output logic [`RADDR_W-1:0] raddr3,
	output logic [`RADDR_W-1:0] raddr4,
	input  logic [`XLEN-1:0]    rdata1,
	input  logic [`XLEN-1:0]    rdata2,
	input  logic [`XLEN-1:0]    rdata3,
	input  logic [`XLEN-1:0]    rdata4,
	output core_pkg::wb_t       wb0,
	output core_pkg::wb_t       wb1
);

	// combinational lane results in the issue cycle
	logic [`XLEN-1:0] y0;
	logic [`XLEN-1:0] y1;

	// writeback stage registers
	logic                wb0_valid;
	logic                wb1_valid;
	logic [`RADDR_W-1:0] wb0_rd;
	logic [`RADDR_W-1:0] wb1_rd;
	logic [`XLEN-1:0]    wb0_data;
	logic [`XLEN-1:0]    wb1_data;

	// both lanes read the file before this pair writes it
	// so lane 1 never sees lane 0's result from the same pair
	assign raddr1 = issue0.rs1;
	assign raddr2 = issue0.rs2;
	assign raddr3 = issue1.rs1;
	assign raddr4 = issue1.rs2;

	alu_lane u_alu_lane0 (
		.op  (issue0.op),
		.a   (rdata1),
		.b   (rdata2),
		.imm (issue0.imm),
		.y   (y0)
	);

	alu_lane u_alu_lane1 (
		.op  (issue1.op),
		.a   (rdata3),
		.b   (rdata4),
		.imm (issue1.imm),
		.y   (y1)
	);

	// anything presented while busy is high is dropped here
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wb0_valid <= 1'b0;
			wb1_valid <= 1'b0;
		end else begin
			wb0_valid <= issue0.valid && !busy;
			wb1_valid <= issue1.valid && !busy;
		end
	end

	// destination and data only matter when the matching valid is set
	always_ff @(posedge clk) begin
		wb0_rd   <= issue0.rd;
		wb1_rd   <= issue1.rd;
		wb0_data <= y0;
		wb1_data <= y1;
	end

	assign wb0 = '{valid: wb0_valid, rd: wb0_rd, data: wb0_data};
	assign wb1 = '{valid: wb1_valid, rd: wb1_rd, data: wb1_data};

	// a cycle with busy high in the sequencer must leave the next writeback empty
	assert property (@(posedge clk) disable iff (!aresetn)
		$past(busy) |-> !(wb0.valid || wb1.valid))
		else $error("exec_stage: writeback valid after a busy cycle");

endmodule

/* hw/reg_file.sv */
`include "core_params.svh"

module reg_file (
	input  logic                clk,
	input  logic                aresetn,

	// write port 1 carries lane 0 writeback
	input  logic                we1,
	input  logic [`RADDR_W-1:0] waddr1,
	input  logic [`XLEN-1:0]    wdata1,

	// write port 2 carries lane 1 writeback and wins on a clash
	input  logic                we2,
	input  logic [`RADDR_W-1:0] waddr2,
	input  logic [`XLEN-1:0]    wdata2,

	// clear port used by the sequencer after reset
	input  logic                clr_en,
	input  logic [`RADDR_W-1:0] clr_addr,

	// ports 1 and 2 feed lane 0, ports 3 and 4 feed lane 1
	input  logic [`RADDR_W-1:0] raddr1,
	input  logic [`RADDR_W-1:0] raddr2,
	input  logic [`RADDR_W-1:0] raddr3,
	input  logic [`RADDR_W-1:0] raddr4,
	output logic [`XLEN-1:0]    rdata1,
	output logic [`XLEN-1:0]    rdata2,
	output logic [`XLEN-1:0]    rdata3,
	output logic [`XLEN-1:0]    rdata4
);

	// x0 is hardwired to zero, so storage starts at register 1
	logic [`XLEN-1:0] regs [1:`NREGS-1];

	// a clear cycle writes zero and blocks both writeback ports
	// when both writeback ports name one register, the later assignment from port 2 lands
	always_ff @(posedge clk) begin
		if (clr_en) begin
			if (clr_addr != '0) begin
				regs[clr_addr] <= '0;
			end
		end else begin
			if (we1 && (waddr1 != '0)) begin
				regs[waddr1] <= wdata1;
			end
			if (we2 && (waddr2 != '0)) begin
				regs[waddr2] <= wdata2;
			end
		end
	end

	// one read port with writeback bypass
	// the bypass lets a pair read what the previous pair is writing in this cycle
	// port 2 is checked first so the bypass agrees with the write priority
	function automatic logic [`XLEN-1:0] read_port(input logic [`RADDR_W-1:0] addr);
		logic [`XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (we2 && (waddr2 == addr)) begin
			val = wdata2;
		end else if (we1 && (waddr1 == addr)) begin
			val = wdata1;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	// all four read ports return zero while reset is held
	assign rdata1 = aresetn ? read_port(raddr1) : '0;
	assign rdata2 = aresetn ? read_port(raddr2) : '0;
	assign rdata3 = aresetn ? read_port(raddr3) : '0;
	assign rdata4 = aresetn ? read_port(raddr4) : '0;

	// the sequencer and the execution stage never write in the same cycle
	// busy gates issue one cycle ahead of writeback, so this relies on FSM and pipe timing
	assert property (@(posedge clk) disable iff (!aresetn)
		clr_en |-> !(we1 || we2))
		else $error("reg_file: clear write collides with a writeback");

endmodule

/* include/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// width of one general purpose register and of every ALU result
`define XLEN 32
// architectural register count, x0 included
`define NREGS 32
// bits needed to name one register
`define RADDR_W 5
// immediate field carried by each issued instruction
`define IMM_W 16

`endif

/* list.f */
+incdir+include
hw/core_pkg.sv
hw/reg_file.sv
hw/alu_lane.sv
hw/exec_stage.sv
hw/clear_counter.sv
hw/clear_fsm.sv
hw/dual_issue_core.sv
sim/tb_dual_issue.sv

/* sim/tb_dual_issue.sv */
`include "core_params.svh"

module tb_dual_issue;

	// random pairs split evenly around the mid-run reset
	localparam int N_PAIRS = 2000;
	// one cycle per pair plus two clear sweeps and the directed pairs, with ample margin
	localparam int MAX_CYCLES = 3 * N_PAIRS;
	localparam int RESET_CYCLES = 4;

	logic             clk;
	logic             aresetn;
	core_pkg::issue_t issue0;
	core_pkg::issue_t issue1;
	logic             busy;
	core_pkg::wb_t    result0;
	core_pkg::wb_t    result1;

	// reference register state, x0 is never written
	logic [`XLEN-1:0] model [0:`NREGS-1];
	// results expected for the pair presented on the previous falling edge
	core_pkg::wb_t exp0;
	core_pkg::wb_t exp1;
	// destinations of the last pair, reused as sources to exercise the bypass
	logic [`RADDR_W-1:0] last_rd0;
	logic [`RADDR_W-1:0] last_rd1;
	// clear cycles still expected before the core takes instructions again
	int clear_left;
	int errors;
	int checks;
	int cycles = 0;

	dual_issue_core u_dual_issue_core (
		.clk     (clk),
		.aresetn (aresetn),
		.issue0  (issue0),
		.issue1  (issue1),
		.busy    (busy),
		.result0 (result0),
		.result1 (result1)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// hard stop if the DUT never leaves clearing or the flow stalls
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// reference ALU written from the opcode list
	function automatic logic [`XLEN-1:0] alu_ref(input core_pkg::alu_op_e op,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b, input logic [`IMM_W-1:0] imm);
		logic [`XLEN-1:0] res;
		case (op)
			core_pkg::OP_ADD:  res = a + b;
			core_pkg::OP_SUB:  res = a - b;
			core_pkg::OP_AND:  res = a & b;
			core_pkg::OP_OR:   res = a | b;
			core_pkg::OP_XOR:  res = a ^ b;
			core_pkg::OP_SLT: begin
				// differing sign bits decide alone, otherwise an unsigned compare works
				if (a[`XLEN-1] != b[`XLEN-1]) begin
					res = a[`XLEN-1] ? `XLEN'(1) : `XLEN'(0);
				end else begin
					res = (a < b) ? `XLEN'(1) : `XLEN'(0);
				end
			end
			core_pkg::OP_ADDI: res = a + `XLEN'($signed(imm));
			core_pkg::OP_LUI:  res = `XLEN'(imm) << (`XLEN - `IMM_W);
			default:           res = '0;
		endcase
		return res;
	endfunction

	function automatic core_pkg::issue_t make_instr(input core_pkg::alu_op_e op,
		input logic [`RADDR_W-1:0] rd, input logic [`RADDR_W-1:0] rs1,
		input logic [`RADDR_W-1:0] rs2, input logic [`IMM_W-1:0] imm);
		core_pkg::issue_t ins;
		ins.valid = 1'b1;
		ins.op = op;
		ins.rd = rd;
		ins.rs1 = rs1;
		ins.rs2 = rs2;
		ins.imm = imm;
		return ins;
	endfunction

	// half of the first sources come from the previous pair's destination
	function automatic core_pkg::issue_t random_instr(input logic [`RADDR_W-1:0] hint);
		core_pkg::issue_t ins;
		ins.valid = ($urandom_range(0, 7) != 0);
		ins.op = core_pkg::alu_op_e'(3'($urandom_range(0, 7)));
		ins.rd = `RADDR_W'($urandom_range(0, `NREGS - 1));
		ins.rs1 = ($urandom_range(0, 1) == 1) ? hint : `RADDR_W'($urandom_range(0, `NREGS - 1));
		ins.rs2 = `RADDR_W'($urandom_range(0, `NREGS - 1));
		ins.imm = `IMM_W'($urandom);
		return ins;
	endfunction

	// an instruction aimed at x0, harmless whether it is dropped or taken
	function automatic core_pkg::issue_t x0_instr;
		core_pkg::issue_t ins;
		ins = random_instr(`RADDR_W'(0));
		ins.valid = 1'b1;
		ins.rd = '0;
		return ins;
	endfunction

	task automatic compare(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// rd and data are only meaningful when a result is expected
	task automatic check_results;
		compare(`XLEN'(result0.valid), `XLEN'(exp0.valid), "lane 0 valid");
		if (exp0.valid) begin
			compare(`XLEN'(result0.rd), `XLEN'(exp0.rd), "lane 0 rd");
			compare(result0.data, exp0.data, "lane 0 data");
		end
		compare(`XLEN'(result1.valid), `XLEN'(exp1.valid), "lane 1 valid");
		if (exp1.valid) begin
			compare(`XLEN'(result1.rd), `XLEN'(exp1.rd), "lane 1 rd");
			compare(result1.data, exp1.data, "lane 1 data");
		end
	endtask

	// both lanes use the state from before the pair, then lane 1 writes last
	// a pair is taken only once the 31 clear cycles after reset release have passed
	task automatic present_pair(input core_pkg::issue_t i0, input core_pkg::issue_t i1);
		logic accept;
		@(negedge clk);
		check_results();
		if (clear_left > 0) begin
			clear_left--;
		end
		accept = (clear_left == 0);
		compare(`XLEN'(busy), `XLEN'(!accept), "busy level");
		exp0.valid = i0.valid && accept;
		exp0.rd = i0.rd;
		exp0.data = alu_ref(i0.op, model[i0.rs1], model[i0.rs2], i0.imm);
		exp1.valid = i1.valid && accept;
		exp1.rd = i1.rd;
		exp1.data = alu_ref(i1.op, model[i1.rs1], model[i1.rs2], i1.imm);
		if (exp0.valid && (i0.rd != '0)) begin
			model[i0.rd] = exp0.data;
		end
		if (exp1.valid && (i1.rd != '0)) begin
			model[i1.rd] = exp1.data;
		end
		issue0 = i0;
		issue1 = i1;
		last_rd0 = i0.rd;
		last_rd1 = i1.rd;
	endtask

	// reset starts on the current falling edge and ends four cycles later
	task automatic apply_reset;
		int i;
		aresetn = 1'b0;
		issue0 = '0;
		issue1 = '0;
		exp0 = '0;
		exp1 = '0;
		for (i = 0; i < `NREGS; i++) begin
			model[i] = '0;
		end
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_results();
			compare(`XLEN'(busy), `XLEN'(1), "busy during reset");
		end
		aresetn = 1'b1;
		clear_left = `NREGS - 1;
	endtask

	// registers 1 to 31 take one cycle each, busy falls after the last one
	task automatic wait_clear;
		int n;
		n = 0;
		while (busy) begin
			n++;
			present_pair(x0_instr(), x0_instr());
		end
		compare(`XLEN'(n), `XLEN'(`NREGS - 1), "clear cycles after reset release");
	endtask

	// read every register through an add with x0, nothing is written
	task automatic sweep_registers;
		int r;
		for (r = 1; r < `NREGS; r += 2) begin
			present_pair(make_instr(core_pkg::OP_ADD, '0, `RADDR_W'(r), '0, '0),
				make_instr(core_pkg::OP_ADD, '0, `RADDR_W'(r + 1), '0, '0));
		end
	endtask

	task automatic directed_pairs;
		// writes aimed at x0 still show their data on the result ports
		present_pair(make_instr(core_pkg::OP_LUI, 5'd0, 5'd0, 5'd0, 16'habcd),
			make_instr(core_pkg::OP_ADDI, 5'd0, 5'd0, 5'd0, 16'h0005));
		// x0 reads zero right after those writes
		present_pair(make_instr(core_pkg::OP_ADD, 5'd3, 5'd0, 5'd0, 16'h0000),
			make_instr(core_pkg::OP_OR, 5'd4, 5'd0, 5'd0, 16'h0000));
		// both lanes target r5 and lane 1's value has to stick
		present_pair(make_instr(core_pkg::OP_ADDI, 5'd5, 5'd0, 5'd0, 16'h0111),
			make_instr(core_pkg::OP_ADDI, 5'd5, 5'd0, 5'd0, 16'h0222));
		// lane 0 sees r5 through the bypass, lane 1 sees r6 from before this pair
		present_pair(make_instr(core_pkg::OP_ADDI, 5'd6, 5'd5, 5'd0, 16'h0000),
			make_instr(core_pkg::OP_ADDI, 5'd7, 5'd6, 5'd0, 16'h0001));
		present_pair(make_instr(core_pkg::OP_ADD, 5'd0, 5'd5, 5'd0, 16'h0000),
			make_instr(core_pkg::OP_ADD, 5'd0, 5'd6, 5'd0, 16'h0000));
		present_pair(make_instr(core_pkg::OP_ADD, 5'd0, 5'd7, 5'd0, 16'h0000),
			make_instr(core_pkg::OP_ADD, 5'd0, 5'd0, 5'd0, 16'h0000));
	endtask

	task automatic run_random(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			present_pair(random_instr(last_rd1), random_instr(last_rd0));
		end
	endtask

	initial begin
		void'($urandom(96));
		aresetn = 1'b0;
		issue0 = '0;
		issue1 = '0;
		exp0 = '0;
		exp1 = '0;
		last_rd0 = '0;
		last_rd1 = '0;
		clear_left = 0;
		errors = 0;
		checks = 0;
		apply_reset();
		wait_clear();
		sweep_registers();
		directed_pairs();
		run_random(N_PAIRS / 2);
		// an empty pair leaves nothing in flight when reset hits mid-run
		present_pair('0, '0);
		apply_reset();
		wait_clear();
		sweep_registers();
		run_random(N_PAIRS / 2);
		@(negedge clk);
		check_results();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
